// ==== source/pingpong_pkg.sv ====
//==========================================================
// Shared constants and types for the ping-pong sample buffer
// Buffer depth is fixed at 256 stereo samples of 2 x 18 bits
// COUNT_W is one bit wider than ADDR_W so a count can reach DEPTH
// Right channel sits in the upper half of a sample word
//==========================================================

package pingpong_pkg;

    //==========================================================
    // Buffer geometry
    //==========================================================
    localparam int unsigned DEPTH   = 256;         // Samples per buffer
    localparam int unsigned ADDR_W  = 8;           // Memory address width
    localparam int unsigned COUNT_W = ADDR_W + 1;  // Holds 0 to DEPTH
    localparam int unsigned CHAN_W  = 18;          // Bits per audio channel

    //==========================================================
    // Data types
    //==========================================================

    // One stereo sample, 36 bits
    typedef struct packed {
        logic [CHAN_W-1:0] right;  // Upper half
        logic [CHAN_W-1:0] left;   // Lower half
    } sample_t;

    // Everything one single-port memory receives in a cycle
    typedef struct packed {
        logic [ADDR_W-1:0] addr;   // Read or write address
        logic              we;     // Write enable
        sample_t           wdata;  // Write data
    } ram_port_t;

endpackage

// ==== source/sample_ram.sv ====
//==========================================================
// Single-port sample memory with a registered read
// Read data appears one cycle after the address
// Read during a write returns the old word
// No reset on the array or the read register
//==========================================================

`timescale 1ns/1ns

module sample_ram import pingpong_pkg::*; (
    input  logic      clk_i,    // System clock
    input  ram_port_t port_i,   // Address, write enable and write data
    output sample_t   rdata_o   // Registered read data
);

    // Storage, DEPTH words of one stereo sample each
    sample_t mem_q [DEPTH];

    // Write port
    always_ff @(posedge clk_i) begin
        if (port_i.we) begin
            mem_q[port_i.addr] <= port_i.wdata;
        end
    end

    // Synchronous read, every cycle like a block memory
    always_ff @(posedge clk_i) begin
        rdata_o <= mem_q[port_i.addr];
    end

endmodule

// ==== source/bank_ctrl.sv ====
//==========================================================
// Bank controller of the ping-pong buffer
// Fills the write bank and swaps only when it is full and
// the reader has drained the other bank
// The writer stalls at DEPTH until the swap, so nothing is lost
// load_o and buffer_ready_o are the same one-cycle pulse
//==========================================================

`timescale 1ns/1ns

module bank_ctrl import pingpong_pkg::*; (
    input  logic               clk_i,           // System clock
    input  logic               rst_ni,          // Synchronous reset, active low

    // Write stream
    input  sample_t            write_data_i,    // Incoming sample
    input  logic               write_valid_i,   // Sample valid
    output logic               write_ready_o,   // Room in the write bank
    output logic [COUNT_W-1:0] write_count_o,   // Fill level of the write bank

    // Read stage side
    input  logic [ADDR_W-1:0]  fetch_addr_i,    // Read address into the read bank
    input  logic               fetch_en_i,      // A fetch is issued this cycle
    input  logic               drained_i,       // Read bank fully delivered
    output logic               load_o,          // New read bank, one cycle
    output logic               buffer_ready_o,  // Same pulse for the outside
    output sample_t            fetch_data_o,    // Data of last cycle's fetch

    // Memory ports
    output ram_port_t          ram0_port_o,
    output ram_port_t          ram1_port_o,
    input  sample_t            ram0_rdata_i,
    input  sample_t            ram1_rdata_i
);

    //==========================================================
    // State
    //==========================================================
    logic [COUNT_W-1:0] wr_count_q;   // Samples in the write bank
    logic               wr_sel_q;     // 0 writes memory 0, 1 writes memory 1
    logic               load_q;       // Registered swap pulse
    logic               fetch_sel_q;  // Bank the pending fetch came from

    logic               write_fire;   // Sample taken this cycle
    logic               swap;         // Swap on this edge
    logic [ADDR_W-1:0]  wr_addr;      // Write address in the write bank
    ram_port_t          wr_port;      // Port seen by the write bank
    ram_port_t          rd_port;      // Port seen by the read bank

    //==========================================================
    // Write handshake and swap rule
    //==========================================================
    assign write_ready_o = (wr_count_q != COUNT_W'(DEPTH));  // Stall when full
    assign write_fire    = write_valid_i && write_ready_o;
    assign swap          = !write_ready_o && drained_i;      // Full and reader done

    // Low bits of the fill count double as the write address
    assign wr_addr = wr_count_q[ADDR_W-1:0];

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_count_q  <= '0;
            wr_sel_q    <= 1'b0;   // Memory 0 is written first
            load_q      <= 1'b0;
            fetch_sel_q <= 1'b1;
        end else begin
            load_q <= swap;        // Pulse shows in the cycle after the swap

            if (swap) begin
                wr_count_q <= '0;          // Fresh bank
                wr_sel_q   <= ~wr_sel_q;   // Filled bank becomes the read bank
            end else if (write_fire) begin
                wr_count_q <= wr_count_q + 1'b1;
            end

            // Remember where the fetch went so its data is picked next cycle
            if (fetch_en_i) begin
                fetch_sel_q <= ~wr_sel_q;
            end
        end
    end

    assign write_count_o  = wr_count_q;
    assign load_o         = load_q;
    assign buffer_ready_o = load_q;

    //==========================================================
    // Memory port steering
    //==========================================================
    always_comb begin
        // Write bank gets the write stream
        wr_port.addr  = wr_addr;
        wr_port.we    = write_fire;
        wr_port.wdata = write_data_i;

        // Read bank only sees the fetch address
        rd_port.addr  = fetch_addr_i;
        rd_port.we    = 1'b0;
        rd_port.wdata = '0;

        if (wr_sel_q) begin
            ram0_port_o = rd_port;
            ram1_port_o = wr_port;
        end else begin
            ram0_port_o = wr_port;
            ram1_port_o = rd_port;
        end
    end

    // Return path from the bank of the last fetch
    assign fetch_data_o = fetch_sel_q ? ram1_rdata_i : ram0_rdata_i;

endmodule

// ==== source/read_stage.sv ====
//==========================================================
// Read stage of the ping-pong buffer
// Fetches DEPTH samples from the read bank after each load pulse
// Memory latency is one cycle, so one fetch can be in flight
// A two-entry queue absorbs that latency under back-pressure
// Valid and data are held until the sample is taken
//==========================================================

`timescale 1ns/1ns

module read_stage import pingpong_pkg::*; (
    input  logic               clk_i,          // System clock
    input  logic               rst_ni,         // Synchronous reset, active low
    input  logic               load_i,         // New buffer in the read bank

    // Memory fetch
    output logic [ADDR_W-1:0]  fetch_addr_o,   // Address in the read bank
    output logic               fetch_en_o,     // Fetch issued this cycle
    input  sample_t            fetch_data_i,   // Data of last cycle's fetch
    output logic               drained_o,      // Nothing left of this buffer

    // Read stream
    output sample_t            read_data_o,
    output logic               read_valid_o,
    input  logic               read_ready_i,
    output logic [COUNT_W-1:0] read_count_o    // Samples taken from this buffer
);

    //==========================================================
    // State
    //==========================================================
    logic [COUNT_W-1:0] fetch_cnt_q;   // Fetches issued for this buffer
    logic [COUNT_W-1:0] taken_q;       // Samples taken by the reader
    logic               busy_q;        // A buffer is being delivered
    logic               inflight_q;    // Fetch data arrives this cycle
    logic [1:0]         q_cnt_q;       // Queue occupancy, 0 to 2
    sample_t            head_q;        // Queue entry presented on the stream
    sample_t            tail_q;        // Second queue entry

    logic               push;          // Returning data enters the queue
    logic               pop;           // Reader takes the head
    logic [1:0]         occ;           // Queue plus in-flight after this take
    logic               more;          // Fetches still due for this buffer

    //==========================================================
    // Fetch issue
    //==========================================================
    assign push = inflight_q;
    assign pop  = read_valid_o && read_ready_i;
    assign occ  = q_cnt_q + {1'b0, inflight_q} - {1'b0, pop};
    assign more = busy_q && (fetch_cnt_q != COUNT_W'(DEPTH));

    // First fetch goes out in the load cycle itself
    assign fetch_en_o   = load_i || (more && (occ < 2'd2));
    assign fetch_addr_o = load_i ? '0 : fetch_cnt_q[ADDR_W-1:0];

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            fetch_cnt_q <= '0;
            taken_q     <= '0;
            busy_q      <= 1'b0;   // Idle, so drained after reset
            inflight_q  <= 1'b0;
            q_cnt_q     <= '0;
        end else begin
            inflight_q <= fetch_en_o;
            q_cnt_q    <= q_cnt_q + {1'b0, push} - {1'b0, pop};

            if (load_i) begin
                fetch_cnt_q <= COUNT_W'(1);   // Address 0 issued now
                taken_q     <= '0;
                busy_q      <= 1'b1;
            end else begin
                if (fetch_en_o) begin
                    fetch_cnt_q <= fetch_cnt_q + 1'b1;
                end
                if (pop) begin
                    taken_q <= taken_q + 1'b1;
                    // Last sample of the buffer leaves
                    if (taken_q == COUNT_W'(DEPTH - 1)) begin
                        busy_q <= 1'b0;
                    end
                end
            end
        end
    end

    //==========================================================
    // Two-entry output queue
    //==========================================================
    // Payload only, occupancy lives in q_cnt_q
    always_ff @(posedge clk_i) begin
        case ({push, pop})
            2'b10: begin
                if (q_cnt_q == 2'd0) begin
                    head_q <= fetch_data_i;
                end else begin
                    tail_q <= fetch_data_i;
                end
            end
            2'b01: begin
                head_q <= tail_q;   // Advance
            end
            2'b11: begin
                if (q_cnt_q == 2'd1) begin
                    head_q <= fetch_data_i;   // Straight into the head
                end else begin
                    head_q <= tail_q;
                    tail_q <= fetch_data_i;
                end
            end
            default: begin
                head_q <= head_q;   // Hold
            end
        endcase
    end

    assign read_valid_o = (q_cnt_q != 2'd0);
    assign read_data_o  = head_q;
    assign read_count_o = taken_q;

    // Done with the buffer and no data on its way
    assign drained_o = !busy_q && !inflight_q && (q_cnt_q == 2'd0);

endmodule

// ==== source/pingpong_buffer.sv ====
//==========================================================
// Ping-pong buffer for a stereo sample stream
// Two 256-word banks, one written while the other is read out
// Only full buffers are read, a partial buffer waits
// A slow reader stalls the writer at the full count
// buffer_ready_o pulses once per loaded buffer
//==========================================================

`timescale 1ns/1ns

module pingpong_buffer import pingpong_pkg::*; (
    input  logic               clk_i,           // System clock
    input  logic               rst_ni,          // Synchronous reset, active low

    // Write stream
    input  sample_t            write_data_i,
    input  logic               write_valid_i,
    output logic               write_ready_o,

    // Read stream
    output sample_t            read_data_o,
    output logic               read_valid_o,
    input  logic               read_ready_i,

    // Status
    output logic               buffer_ready_o,  // One cycle per new buffer
    output logic [COUNT_W-1:0] write_count_o,   // Write bank fill level
    output logic [COUNT_W-1:0] read_count_o     // Read position in the buffer
);

    //==========================================================
    // Internal connections
    //==========================================================
    ram_port_t         ram0_port;    // Controller to memory 0
    ram_port_t         ram1_port;    // Controller to memory 1
    sample_t           ram0_rdata;
    sample_t           ram1_rdata;
    sample_t           fetch_data;   // Read bank data to the read stage
    logic [ADDR_W-1:0] fetch_addr;
    logic              fetch_en;
    logic              load;         // New read buffer pulse
    logic              drained;      // Read stage finished its buffer

    // Bank selection, swap and port steering
    bank_ctrl u_bank_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .write_data_i   (write_data_i),
        .write_valid_i  (write_valid_i),
        .write_ready_o  (write_ready_o),
        .write_count_o  (write_count_o),
        .fetch_addr_i   (fetch_addr),
        .fetch_en_i     (fetch_en),
        .drained_i      (drained),
        .load_o         (load),
        .buffer_ready_o (buffer_ready_o),
        .fetch_data_o   (fetch_data),
        .ram0_port_o    (ram0_port),
        .ram1_port_o    (ram1_port),
        .ram0_rdata_i   (ram0_rdata),
        .ram1_rdata_i   (ram1_rdata)
    );

    // Read-out sequencing and stream queue
    read_stage u_read_stage (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .load_i       (load),
        .fetch_addr_o (fetch_addr),
        .fetch_en_o   (fetch_en),
        .fetch_data_i (fetch_data),
        .drained_o    (drained),
        .read_data_o  (read_data_o),
        .read_valid_o (read_valid_o),
        .read_ready_i (read_ready_i),
        .read_count_o (read_count_o)
    );

    //==========================================================
    // Sample memories
    //==========================================================
    sample_ram ram0 (
        .clk_i   (clk_i),
        .port_i  (ram0_port),
        .rdata_o (ram0_rdata)
    );

    sample_ram ram1 (
        .clk_i   (clk_i),
        .port_i  (ram1_port),
        .rdata_o (ram1_rdata)
    );

endmodule

// ==== sim/tb_pingpong_buffer.sv ====
//==========================================================
// Testbench for the ping-pong sample buffer
// Random writes and reads from seed 49 against a queue model
// Stops at the first mismatch and every wait has its own cycle limit
// Swap timing is not predicted but every buffer_ready_o pulse is validated
//==========================================================

`timescale 1ns/1ns

module tb_pingpong_buffer import pingpong_pkg::*; ();

    localparam int unsigned PARTIAL_FILL = 77;  // Samples left in the last, unread buffer

    //==========================================================
    // DUT signals
    //==========================================================
    logic               clk_i;
    logic               rst_ni;
    sample_t            write_data_i;
    logic               write_valid_i;
    logic               write_ready_o;
    sample_t            read_data_o;
    logic               read_valid_o;
    logic               read_ready_i;
    logic               buffer_ready_o;
    logic [COUNT_W-1:0] write_count_o;
    logic [COUNT_W-1:0] read_count_o;

    // Reference model
    sample_t     exp_q[$];   // Accepted samples in write order
    int unsigned m_wcount;   // Accepted since the last swap
    int unsigned m_taken;    // Taken from the current read buffer
    int unsigned m_loaded;   // Buffers loaded so far
    int unsigned accepted;   // All accepted writes

    pingpong_buffer dut0 (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .write_data_i   (write_data_i),
        .write_valid_i  (write_valid_i),
        .write_ready_o  (write_ready_o),
        .read_data_o    (read_data_o),
        .read_valid_o   (read_valid_o),
        .read_ready_i   (read_ready_i),
        .buffer_ready_o (buffer_ready_o),
        .write_count_o  (write_count_o),
        .read_count_o   (read_count_o)
    );

    always #50 clk_i = ~clk_i;  // 100 ns period

    //==========================================================
    // Failure reporting and compare tasks
    //==========================================================
    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic fail_plain(input string what);
        $display("Failure: %s", what);
        abort_run();
    endtask

    task automatic check_sample(input string name, input sample_t act, input sample_t want);
        if (act !== want) begin
            $display("[ERROR] %s: got R=0x%h L=0x%h, expected R=0x%h L=0x%h",
                     name, act.right, act.left, want.right, want.left);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input logic [COUNT_W-1:0] act,
                               input logic [COUNT_W-1:0] want);
        if (act !== want) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, act, want);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic want);
        if (act !== want) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, act, want);
            abort_run();
        end
    endtask

    //==========================================================
    // Per-cycle model
    //==========================================================
    task automatic check_idle_outputs();
        check_bit("write_ready_o", write_ready_o, 1'b1);
        check_bit("read_valid_o", read_valid_o, 1'b0);
        check_bit("buffer_ready_o", buffer_ready_o, 1'b0);
        check_count("write_count_o", write_count_o, '0);
        check_count("read_count_o", read_count_o, '0);
    endtask

    // Runs at the falling edge where registered outputs have settled
    task automatic check_cycle();
        // Read position still shows the old buffer in the pulse cycle
        check_count("read_count_o", read_count_o, COUNT_W'(m_taken));
        if (buffer_ready_o) begin
            if (m_wcount != DEPTH) begin
                fail_plain("buffer_ready_o pulsed without a full write buffer");
            end else if (m_loaded != 0 && m_taken != DEPTH) begin
                fail_plain("buffer_ready_o pulsed before the reader took the previous buffer");
            end else begin
                m_loaded++;
                m_taken  = 0;
                m_wcount = 0;   // Write bank was cleared on the swap edge
            end
        end
        check_count("write_count_o", write_count_o, COUNT_W'(m_wcount));
        check_bit("write_ready_o", write_ready_o, m_wcount != DEPTH);
    endtask

    task automatic take_sample();
        sample_t want;
        if (m_loaded == 0 || m_taken == DEPTH || exp_q.size() == 0) begin
            fail_plain("read_valid_o is high with no sample of a loaded buffer left");
        end else begin
            want = exp_q.pop_front();
            check_sample("read_data_o", read_data_o, want);
            m_taken++;
        end
    endtask

    // Check the outputs and drive the next inputs at one falling edge
    task automatic step(input int unsigned wr_pct, input int unsigned rd_pct, input bit wr_on);
        sample_t s;
        logic    wv;
        logic    rr;
        @(negedge clk_i);
        check_cycle();
        s.right = CHAN_W'($urandom);
        s.left  = CHAN_W'($urandom);
        wv = wr_on && (($urandom % 100) < wr_pct);   // Never looks at ready
        rr = ($urandom % 100) < rd_pct;
        write_data_i  = s;
        write_valid_i = wv;
        read_ready_i  = rr;
        // Handshakes that the next rising edge completes
        if (wv && write_ready_o) begin
            exp_q.push_back(s);
            m_wcount++;
            accepted++;
        end
        if (rr && read_valid_o) begin
            take_sample();
        end
    endtask

    //==========================================================
    // Test phases
    //==========================================================
    task automatic apply_reset();
        rst_ni = 1'b0;
        repeat (2) begin
            @(negedge clk_i);
            check_idle_outputs();   // Values under reset
        end
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_idle_outputs();       // First cycle out of reset
    endtask

    task automatic run_until_loaded(input int unsigned target, input int unsigned wr_pct,
                                    input int unsigned rd_pct, input int unsigned limit);
        int unsigned cycles;
        cycles = 0;
        while (m_loaded < target) begin
            if (cycles == limit) begin
                fail_plain("timed out waiting for buffer_ready_o pulses");
            end else begin
                step(wr_pct, rd_pct, 1'b1);
                cycles++;
            end
        end
    endtask

    // Writer stops with a partial buffer in the write bank
    task automatic fill_partial(input int unsigned limit);
        int unsigned cycles;
        cycles = 0;
        while (m_wcount != PARTIAL_FILL) begin
            if (cycles == limit) begin
                fail_plain("timed out filling the partial buffer");
            end else begin
                step(80, 70, 1'b1);
                cycles++;
            end
        end
    endtask

    task automatic drain_all(input int unsigned limit);
        int unsigned cycles;
        cycles = 0;
        while (!(m_loaded == accepted / DEPTH && m_taken == DEPTH)) begin
            if (cycles == limit) begin
                fail_plain("timed out waiting for the reader to take every full buffer");
            end else begin
                step(0, 75, 1'b0);
                cycles++;
            end
        end
    endtask

    // The partial buffer must never show up on the read stream
    task automatic watch_idle(input int unsigned cycles);
        repeat (cycles) begin
            step(0, 50, 1'b0);
            check_bit("read_valid_o", read_valid_o, 1'b0);
            check_bit("buffer_ready_o", buffer_ready_o, 1'b0);
        end
    endtask

    //==========================================================
    // Main sequence
    //==========================================================
    initial begin
        void'($urandom(49));
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        write_data_i  = '0;
        write_valid_i = 1'b0;
        read_ready_i  = 1'b0;
        m_wcount      = 0;
        m_taken       = 0;
        m_loaded      = 0;
        accepted      = 0;

        apply_reset();
        run_until_loaded(3, 80, 90, 20 * DEPTH);   // Fast reader
        run_until_loaded(5, 80, 10, 50 * DEPTH);   // Slow reader so the writer stalls at full
        run_until_loaded(7, 80, 60, 30 * DEPTH);   // Mixed rates
        fill_partial(20 * DEPTH);
        drain_all(10 * DEPTH);
        watch_idle(3 * DEPTH);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== vlog.f ====
source/pingpong_pkg.sv
source/sample_ram.sv
source/bank_ctrl.sv
source/read_stage.sv
source/pingpong_buffer.sv
sim/tb_pingpong_buffer.sv
